// ==== floo_la_pkg.sv ====
// Look-ahead router port package
//
// Shared types for one input port of a 2D-mesh router with look-ahead
// routing. This covers the router coordinate, the output direction, and the
// two ways a flit word is decoded: as a header or as a body word.
package floo_la_pkg;

  // width of the flit word at the port boundary
  localparam int unsigned FlitWidth = 32;

  // one valid strobe per output direction
  localparam int unsigned NumDirs = 5;

  // output direction at a router, also used as the look-ahead field
  typedef enum logic [2:0] {
    Eject = 3'd0,
    North = 3'd1,
    East  = 3'd2,
    South = 3'd3,
    West  = 3'd4
  } route_dir_e;

  // mesh coordinate, arithmetic wraps modulo 16
  typedef struct packed {
    logic [3:0] x;
    logic [3:0] y;
  } xy_id_t;

  // head flit layout
  typedef struct packed {
    logic        last;
    xy_id_t      dst_id;
    xy_id_t      src_id;
    route_dir_e  look_ahead_routing;
    logic [11:0] rsvd;
  } hdr_t;

  // body flit layout, last shares the MSB with the header view
  typedef struct packed {
    logic        last;
    logic [30:0] payload;
  } body_t;

  // the same 32-bit word, read by position in the packet
  typedef union packed {
    hdr_t  hdr;
    body_t body;
  } flit_u;

endpackage

// ==== floo_flit_if.sv ====
// Flit stage interface
//
// Carries one pipeline stage's flit together with its framing, its output
// direction at this router and the look-ahead direction for the next router.
interface floo_flit_if import floo_la_pkg::*; ();

  logic       valid;
  logic       is_head;
  flit_u      flit;
  route_dir_e dir;
  route_dir_e la_dir;

  // producer of the registered flit
  modport src (
    output valid, is_head, flit, dir
  );

  // look-ahead logic fills in the next router's direction
  modport la (
    input  flit, dir,
    output la_dir
  );

  // consumer of the complete stage
  modport dst (
    input valid, is_head, flit, dir, la_dir
  );

endinterface

// ==== floo_input_stage.sv ====
// Input stage of the look-ahead router port
//
// Registers each incoming flit with its valid strobe and tracks packet
// framing. A head takes its output direction from the look-ahead field
// it carries. Body flits reuse the direction stored for their packet.
module floo_input_stage import floo_la_pkg::*; (
  input  logic     clk_i,
  input  logic     reset_i,
  input  logic     flit_valid_i,
  input  flit_u    flit_i,
  floo_flit_if.src flit_o
);

  logic       in_pkt_q;
  route_dir_e pkt_dir_q;
  logic       is_head;
  route_dir_e dir_d;

  // outside a packet the next valid flit opens one
  assign is_head = ~in_pkt_q;
  assign dir_d   = is_head ? flit_i.hdr.look_ahead_routing : pkt_dir_q;

  // framing state
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      in_pkt_q  <= 1'b0;
      pkt_dir_q <= Eject;
    end else if (flit_valid_i) begin
      // last sits in the same bit for both views
      in_pkt_q  <= ~flit_i.hdr.last;
      pkt_dir_q <= dir_d;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      flit_o.valid <= 1'b0;
    end else begin
      flit_o.valid <= flit_valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (flit_valid_i) begin
      flit_o.flit    <= flit_i;
      flit_o.is_head <= is_head;
      flit_o.dir     <= dir_d;
    end
  end

  // upstream look-ahead only ever produces one of the five directions
  head_dir_in_range_a : assert property (
    @(posedge clk_i) disable iff (reset_i)
    flit_valid_i && is_head |->
      flit_i.hdr.look_ahead_routing inside {Eject, North, East, South, West}
  );

endmodule

// ==== floo_route_select.sv ====
// XY route selection
//
// Dimension-ordered routing for a given router coordinate. The x offset
// is resolved first, then y. A flit already at its destination ejects.
module floo_route_select import floo_la_pkg::*; (
  input  xy_id_t     xy_id_i,
  input  xy_id_t     dst_id_i,
  output route_dir_e route_dir_o
);

  logic x_gt;
  logic x_lt;
  logic y_gt;
  logic y_lt;

  // destination relative to this coordinate
  assign x_gt = dst_id_i.x > xy_id_i.x;
  assign x_lt = dst_id_i.x < xy_id_i.x;
  assign y_gt = dst_id_i.y > xy_id_i.y;
  assign y_lt = dst_id_i.y < xy_id_i.y;

  always_comb begin
    route_dir_o = Eject;
    if (x_gt) begin
      route_dir_o = East;
    end else if (x_lt) begin
      route_dir_o = West;
    end else if (y_gt) begin
      // x done, now move along y
      route_dir_o = North;
    end else if (y_lt) begin
      route_dir_o = South;
    end
  end

endmodule

// ==== floo_look_ahead_routing.sv ====
// Look-ahead routing
//
// Steps this router's coordinate once in the flit's output direction to
// find the neighbour, then runs XY routing at the neighbour for the
// header's destination. The result is the direction the neighbour will use.
module floo_look_ahead_routing import floo_la_pkg::*; (
  input  xy_id_t  xy_id_i,
  floo_flit_if.la flit_io
);

  xy_id_t     xy_id_nxt;
  route_dir_e la_dir;

  // neighbour coordinate, 4-bit fields wrap at the mesh edge
  always_comb begin
    xy_id_nxt = xy_id_i;
    case (flit_io.dir)
      North: begin
        xy_id_nxt.y = xy_id_i.y + 4'd1;
      end
      South: begin
        xy_id_nxt.y = xy_id_i.y - 4'd1;
      end
      East: begin
        xy_id_nxt.x = xy_id_i.x + 4'd1;
      end
      West: begin
        xy_id_nxt.x = xy_id_i.x - 4'd1;
      end
      default: begin
        // eject stays at this router
        xy_id_nxt = xy_id_i;
      end
    endcase
  end

  // body words decode dst_id from payload bits, only heads use the result
  floo_route_select i_route_select (
    .xy_id_i     (xy_id_nxt),
    .dst_id_i    (flit_io.flit.hdr.dst_id),
    .route_dir_o (la_dir)
  );

  assign flit_io.la_dir = la_dir;

endmodule

// ==== floo_output_stage.sv ====
// Output stage of the look-ahead router port
//
// Writes the next router's direction into the look-ahead field of head
// flits, leaves body flits untouched, and registers the flit onto the
// output port selected by its direction.
module floo_output_stage import floo_la_pkg::*; (
  input  logic               clk_i,
  input  logic               reset_i,
  floo_flit_if.dst           flit_i,
  output logic [NumDirs-1:0] out_valid_o,
  output flit_u              flit_o
);

  flit_u              flit_d;
  logic [NumDirs-1:0] out_valid_d;

  // header rewrite
  always_comb begin
    flit_d = flit_i.flit;
    if (flit_i.is_head) begin
      flit_d.hdr.look_ahead_routing = flit_i.la_dir;
    end
  end

  // one strobe per direction
  always_comb begin
    out_valid_d = '0;
    if (flit_i.valid) begin
      out_valid_d[flit_i.dir] = 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      out_valid_o <= '0;
    end else begin
      out_valid_o <= out_valid_d;
    end
  end

  always_ff @(posedge clk_i) begin
    if (flit_i.valid) begin
      flit_o <= flit_d;
    end
  end

  // never more than one port driven at a time
  out_valid_onehot_a : assert property (
    @(posedge clk_i) disable iff (reset_i)
    $onehot0(out_valid_o)
  );

endmodule

// ==== floo_la_router_port.sv ====
// Look-ahead router input port
//
// One input port of a 2D-mesh router. Each flit is forwarded out of the
// direction decided one hop earlier, and head flits leave with the XY
// route of the neighbour they are sent to. Two register stages in total.
module floo_la_router_port import floo_la_pkg::*; (
  input  logic                 clk_i,
  input  logic                 reset_i,
  input  xy_id_t               xy_id_i,
  input  logic                 flit_valid_i,
  input  logic [FlitWidth-1:0] flit_i,
  output logic [NumDirs-1:0]   out_valid_o,
  output logic [FlitWidth-1:0] flit_o
);

  flit_u flit_in;
  flit_u flit_out;

  // registered flit shared by the look-ahead and output logic
  floo_flit_if in_flit ();

  assign flit_in = flit_i;

  floo_input_stage i_input_stage (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .flit_valid_i (flit_valid_i),
    .flit_i       (flit_in),
    .flit_o       (in_flit.src)
  );

  // route for the next hop, computed in the same cycle
  floo_look_ahead_routing i_look_ahead_routing (
    .xy_id_i (xy_id_i),
    .flit_io (in_flit.la)
  );

  floo_output_stage i_output_stage (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .flit_i      (in_flit.dst),
    .out_valid_o (out_valid_o),
    .flit_o      (flit_out)
  );

  assign flit_o = flit_out;

endmodule

// ==== tb_clk_gen.sv ====
// Testbench clock and reset
//
// Free-running 10 ns clock. Reset is held high for the first two
// rising edges and released right after the second one.
module tb_clk_gen (
  output logic clk_o,
  output logic reset_o
);

  timeunit 1ns;
  timeprecision 100ps;

  initial begin
    clk_o = 1'b0;
    forever #5 clk_o = ~clk_o;
  end

  initial begin
    reset_o = 1'b1;
    repeat (2) @(posedge clk_o);
    reset_o <= 1'b0;
  end

endmodule

// ==== tb_floo_la_router_port.sv ====
// Testbench for the look-ahead router port
//
// Directed tests drive flits on the falling edge. A reference model applies
// the packet framing and XY look-ahead rules and predicts every output two
// rising edges after its input. Stops at the first mismatch.
module tb_floo_la_router_port import floo_la_pkg::*; ();

  timeunit 1ns;
  timeprecision 100ps;

  // tests take roughly 250 cycles, allow about four times that
  localparam int unsigned MaxCycles = 1000;

  logic                 clk;
  logic                 rst;
  xy_id_t               xy_id;
  logic                 flit_valid;
  logic [FlitWidth-1:0] flit_in;
  logic [NumDirs-1:0]   out_valid;
  logic [FlitWidth-1:0] flit_out;

  logic [15:0] lfsr_state;
  string       test_name;
  int unsigned cycle_count = 0;
  int unsigned fail_count;

  // model framing state
  logic       model_in_pkt;
  route_dir_e model_pkt_dir;

  // model copy of the input register
  logic       s0_valid;
  logic       s0_head;
  route_dir_e s0_dir;
  flit_u      s0_flit;

  // what the outputs must show at the next check
  logic       s1_valid;
  route_dir_e s1_dir;
  flit_u      s1_flit;

  tb_clk_gen clk_gen_i (
    .clk_o   (clk),
    .reset_o (rst)
  );

  floo_la_router_port dut_i (
    .clk_i        (clk),
    .reset_i      (rst),
    .xy_id_i      (xy_id),
    .flit_valid_i (flit_valid),
    .flit_i       (flit_in),
    .out_valid_o  (out_valid),
    .flit_o       (flit_out)
  );

  task automatic stop_on_error(input string msg);
    fail_count++;
    $display("%s", msg);
    $display("Test failures found");
    $fatal(1, "simulation stopped at the first error");
  endtask

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count >= MaxCycles) begin
      stop_on_error($sformatf("timeout: tests still running after %0d cycles", cycle_count));
    end
  end

  // galois form, taps 16 14 13 11
  function automatic logic [15:0] lfsr_next(input logic [15:0] state);
    logic [15:0] nxt;
    if (state[0]) begin
      nxt = (state >> 1) ^ 16'hB400;
    end else begin
      nxt = state >> 1;
    end
    return nxt;
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] val;
    val = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      val = {val[30:0], lfsr_state[0]};
    end
    return val;
  endfunction

  // one hop in the given direction, coordinates wrap modulo 16
  function automatic xy_id_t neighbour(input xy_id_t cur, input route_dir_e dir);
    xy_id_t nb;
    nb = cur;
    case (dir)
      North: nb.y = 4'((int'(cur.y) + 1) % 16);
      South: nb.y = 4'((int'(cur.y) + 15) % 16);
      East:  nb.x = 4'((int'(cur.x) + 1) % 16);
      West:  nb.x = 4'((int'(cur.x) + 15) % 16);
      default: nb = cur;
    endcase
    return nb;
  endfunction

  // dimension-ordered route at router n towards d
  function automatic route_dir_e xy_route(input xy_id_t n, input xy_id_t d);
    route_dir_e res;
    if (int'(d.x) > int'(n.x)) begin
      res = East;
    end else if (int'(d.x) < int'(n.x)) begin
      res = West;
    end else if (int'(d.y) > int'(n.y)) begin
      res = North;
    end else if (int'(d.y) < int'(n.y)) begin
      res = South;
    end else begin
      res = Eject;
    end
    return res;
  endfunction

  function automatic route_dir_e port_of(input logic [NumDirs-1:0] valid_vec);
    route_dir_e dir;
    dir = Eject;
    for (int i = 0; i < NumDirs; i++) begin
      if (valid_vec[i]) begin
        dir = route_dir_e'(3'(i));
      end
    end
    return dir;
  endfunction

  function automatic flit_u make_head(input logic is_tail, input xy_id_t dst,
                                      input route_dir_e dir);
    flit_u f;
    f.hdr.last               = is_tail;
    f.hdr.dst_id             = dst;
    f.hdr.src_id             = xy_id_t'(8'(rand_bits(8)));
    f.hdr.look_ahead_routing = dir;
    f.hdr.rsvd               = 12'(rand_bits(12));
    return f;
  endfunction

  function automatic flit_u make_body(input logic is_tail, input logic [30:0] payload);
    flit_u f;
    f.body.last    = is_tail;
    f.body.payload = payload;
    return f;
  endfunction

  task automatic check_dir(input string name, input route_dir_e exp, input route_dir_e act);
    if (act !== exp) begin
      stop_on_error($sformatf("[FAIL] %s: expected port %s, actual port %s",
                              name, exp.name(), act.name()));
    end
  endtask

  task automatic check_flit(input string name, input flit_u exp, input flit_u act);
    if (act !== exp) begin
      stop_on_error($sformatf("[FAIL] %s: expected flit %h, actual flit %h", name, exp, act));
    end
  endtask

  // one clock cycle: check outputs, advance the model, drive new inputs
  task automatic apply_cycle(input logic valid, input flit_u flit, input xy_id_t xy);
    flit_u      rewritten;
    logic       head;
    route_dir_e dir;
    @(negedge clk);
    if (s1_valid) begin
      if ($countones(out_valid) != 1) begin
        stop_on_error($sformatf("%s: a flit was due but out_valid_o is %b",
                                test_name, out_valid));
      end
      check_dir(test_name, s1_dir, port_of(out_valid));
      check_flit(test_name, s1_flit, flit_u'(flit_out));
    end else if (out_valid !== '0) begin
      stop_on_error($sformatf("%s: out_valid_o is %b although no flit was due",
                              test_name, out_valid));
    end
    // the neighbour route uses the coordinate present at the output edge
    rewritten = s0_flit;
    if (s0_valid && s0_head) begin
      rewritten.hdr.look_ahead_routing = xy_route(neighbour(xy, s0_dir), s0_flit.hdr.dst_id);
    end
    s1_valid = s0_valid;
    s1_dir   = s0_dir;
    s1_flit  = rewritten;
    s0_valid = valid;
    if (valid) begin
      head          = !model_in_pkt;
      dir           = head ? flit.hdr.look_ahead_routing : model_pkt_dir;
      s0_head       = head;
      s0_dir        = dir;
      s0_flit       = flit;
      model_in_pkt  = !flit.hdr.last;
      model_pkt_dir = dir;
    end
    flit_valid = valid;
    flit_in    = flit;
    xy_id      = xy;
  endtask

  task automatic flush(input xy_id_t xy);
    repeat (2) apply_cycle(1'b0, '0, xy);
  endtask

  task automatic send_packet(input xy_id_t here, input xy_id_t dst, input route_dir_e dir,
                             input int len);
    apply_cycle(1'b1, make_head(len == 1, dst, dir), here);
    for (int i = 1; i < len; i++) begin
      apply_cycle(1'b1, make_body(i == len - 1, 31'(rand_bits(31))), here);
    end
  endtask

  task automatic test_reset();
    test_name = "reset";
    repeat (4) apply_cycle(1'b0, '0, '0);
  endtask

  task automatic test_single_flit();
    xy_id_t     here;
    xy_id_t     dsts [5];
    route_dir_e dir;
    test_name = "single_flit";
    here = '{x: 4'd5, y: 4'd7};
    for (int d = 0; d < NumDirs; d++) begin
      dir = route_dir_e'(3'(d));
      // first target is the neighbour itself, so the next hop ejects
      dsts[0] = neighbour(here, dir);
      dsts[1] = '{x: 4'd0, y: 4'd0};
      dsts[2] = '{x: 4'd15, y: 4'd15};
      dsts[3] = '{x: 4'd5, y: 4'd12};
      dsts[4] = '{x: 4'd2, y: 4'd7};
      for (int k = 0; k < 5; k++) begin
        apply_cycle(1'b1, make_head(1'b1, dsts[k], dir), here);
        apply_cycle(1'b0, '0, here);
      end
    end
    flush(here);
  endtask

  task automatic test_multi_flit();
    xy_id_t here;
    test_name = "multi_flit";
    here = '{x: 4'd3, y: 4'd3};
    apply_cycle(1'b1, make_head(1'b0, '{x: 4'd9, y: 4'd1}, East), here);
    // body bits under the look-ahead field hold a value no head may carry
    apply_cycle(1'b1, make_body(1'b0, 31'(rand_bits(31)) | 31'h7000), here);
    apply_cycle(1'b1, make_body(1'b0, 31'(rand_bits(31))), here);
    apply_cycle(1'b1, make_body(1'b1, 31'(rand_bits(31))), here);
    // word after the tail opens a new packet
    apply_cycle(1'b1, make_head(1'b1, '{x: 4'd3, y: 4'd0}, South), here);
    flush(here);
  endtask

  task automatic test_back_to_back();
    xy_id_t     here;
    route_dir_e dirs [6];
    int         lens [6];
    test_name = "back_to_back";
    here = '{x: 4'd8, y: 4'd8};
    dirs = '{North, West, East, Eject, South, East};
    lens = '{2, 1, 3, 1, 2, 4};
    for (int r = 0; r < 2; r++) begin
      for (int p = 0; p < 6; p++) begin
        send_packet(here, xy_id_t'(8'(rand_bits(8))), dirs[p], lens[p]);
      end
    end
    flush(here);
  endtask

  task automatic test_random();
    xy_id_t     here;
    xy_id_t     dst;
    route_dir_e dir;
    int         len;
    test_name = "random";
    // mesh corners first, to step across the wrap
    send_packet('{x: 4'd0, y: 4'd0}, xy_id_t'(8'(rand_bits(8))), West, 1);
    send_packet('{x: 4'd0, y: 4'd0}, xy_id_t'(8'(rand_bits(8))), South, 2);
    send_packet('{x: 4'd15, y: 4'd15}, xy_id_t'(8'(rand_bits(8))), East, 1);
    send_packet('{x: 4'd15, y: 4'd15}, xy_id_t'(8'(rand_bits(8))), North, 2);
    for (int p = 0; p < 70; p++) begin
      here = xy_id_t'(8'(rand_bits(8)));
      dst  = xy_id_t'(8'(rand_bits(8)));
      dir  = route_dir_e'(3'(rand_bits(3) % 5));
      len  = 1 + int'(rand_bits(2));
      send_packet(here, dst, dir, len);
    end
    flush(here);
  endtask

  initial begin
    flit_valid    = 1'b0;
    flit_in       = '0;
    xy_id         = '0;
    lfsr_state    = 16'd50;
    fail_count    = 0;
    test_name     = "init";
    model_in_pkt  = 1'b0;
    model_pkt_dir = Eject;
    s0_valid      = 1'b0;
    s0_head       = 1'b0;
    s0_dir        = Eject;
    s0_flit       = '0;
    s1_valid      = 1'b0;
    s1_dir        = Eject;
    s1_flit       = '0;
    @(posedge clk);
    while (rst) @(negedge clk);
    test_reset();
    test_single_flit();
    test_multi_flit();
    test_back_to_back();
    test_random();
    if (fail_count == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

// ==== compile.f ====
floo_la_pkg.sv
floo_flit_if.sv
floo_input_stage.sv
floo_route_select.sv
floo_look_ahead_routing.sv
floo_output_stage.sv
floo_la_router_port.sv
tb_clk_gen.sv
tb_floo_la_router_port.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the look-ahead router port testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
  -f compile.f \
  --top-module tb_floo_la_router_port \
  --Mdir obj_dir \
  -o sim_tb

# the log decides pass or fail, so the exit code of the run is not used here
./obj_dir/sim_tb 2>&1 | tee sim.log

if grep -q 'Test failures found' sim.log; then
  echo "simulation reported failures"
  exit 1
fi

if ! grep -q 'All tests passed!' sim.log; then
  echo "simulation ended without a result"
  exit 1
fi

echo "simulation passed"
